//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_fu
FILELIST  = build.f
LOG       = sim.log
RUNARGS   = +verilator+error+limit+10

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNARGS) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- alu.sv
`timescale 1ns/1ps
`include "fu_defs.svh"

// RV32I integer ops, purely combinational
module alu (
    input  logic [`XLEN-1:0]  opa,
    input  logic [`XLEN-1:0]  opb,
    input  fu_pkg::alu_func_t func,
    output logic [`XLEN-1:0]  result
);
    import fu_pkg::*;

    logic signed [`XLEN-1:0] sopa, sopb;  // signed views for slt / sra
    logic [4:0]              shamt;

    assign sopa  = opa;
    assign sopb  = opb;
    assign shamt = opb[4:0];  // only low five bits count

    always_comb begin
        case (func)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_AND:  result = opa & opb;
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            // compares give 0 or 1
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, sopa < sopb};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, opa < opb};
            ALU_SRL:  result = opa >> shamt;
            ALU_SLL:  result = opa << shamt;
            ALU_SRA:  result = sopa >>> shamt;  // keeps sign
            default:  result = `POISON_ALU;
        endcase
    end

endmodule

//--- alu_unit.sv
`timescale 1ns/1ps
`include "fu_defs.svh"

// single cycle ALU lane, no state
module alu_unit (
    input  logic                   valid,
    input  fu_pkg::inst_t          inst,
    input  logic [`XLEN-1:0]       pc,
    input  fu_pkg::alu_func_t      func,
    input  logic [`XLEN-1:0]       op1,
    input  logic [`XLEN-1:0]       op2,
    input  logic [`PRN_WIDTH-1:0]  dest_prn,
    input  logic [`ROBN_WIDTH-1:0] robn,
    input  fu_pkg::opa_select_t    opa_select,
    input  fu_pkg::opb_select_t    opb_select,
    input  logic                   cond_branch,
    input  logic                   uncond_branch,
    output logic                   prepared,
    output logic [`XLEN-1:0]       result,
    output logic [`PRN_WIDTH-1:0]  done_dest_prn,
    output logic [`ROBN_WIDTH-1:0] done_robn,
    output logic                   take_branch,
    output logic                   cond_branch_done
);
    logic [`XLEN-1:0] opa, opb;
    logic             cmp_take;

    assign prepared         = valid;  // zero latency
    assign done_dest_prn    = dest_prn;
    assign done_robn        = robn;
    assign cond_branch_done = valid & cond_branch;  // rob executed flag
    // jal/jalr always redirect, branches only if compare passes
    assign take_branch      = uncond_branch | (cond_branch & cmp_take);

    operand_select i_operand_select (
        .inst       (inst),
        .pc         (pc),
        .op1        (op1),
        .op2        (op2),
        .opa_select (opa_select),
        .opb_select (opb_select),
        .opa        (opa),
        .opb        (opb)
    );

    // for a branch the alu adds pc + b_imm, result is the target
    alu i_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (func),
        .result (result)
    );

    // compare runs on raw register values, not muxed operands
    branch_cond i_branch_cond (
        .funct3 (inst.b.funct3),
        .rs1    (op1),
        .rs2    (op2),
        .take   (cmp_take)
    );

endmodule

//--- branch_cond.sv
`timescale 1ns/1ps
`include "fu_defs.svh"

// conditional branch compare, funct3 selects the test
module branch_cond (
    input  logic [2:0]       funct3,
    input  logic [`XLEN-1:0] rs1,
    input  logic [`XLEN-1:0] rs2,
    output logic             take
);
    logic signed [`XLEN-1:0] srs1, srs2;

    assign srs1 = rs1;
    assign srs2 = rs2;

    always_comb begin
        case (funct3)
            3'b000:  take = rs1 == rs2;    // beq
            3'b001:  take = rs1 != rs2;    // bne
            3'b100:  take = srs1 < srs2;   // blt
            3'b101:  take = srs1 >= srs2;  // bge
            3'b110:  take = rs1 < rs2;     // bltu
            3'b111:  take = rs1 >= rs2;    // bgeu
            default: take = 1'b0;          // 010, 011 reserved
        endcase
    end

endmodule

//--- build.f
+incdir+.
fu_pkg.sv
operand_select.sv
alu.sv
branch_cond.sv
alu_unit.sv
mult_unit.sv
fu.sv
fu_properties.sv
tb_fu.sv

//--- fu.sv
`timescale 1ns/1ps
`include "fu_defs.svh"

// execute stage top, one alu lane and one mult lane
module fu (
    input  logic                   clock,
    input  logic                   rst,
    // alu issue from the reservation station
    input  logic                   alu_valid,
    input  fu_pkg::inst_t          alu_inst,
    input  logic [`XLEN-1:0]       alu_pc,
    input  fu_pkg::alu_func_t      alu_func,
    input  logic [`XLEN-1:0]       alu_op1,
    input  logic [`XLEN-1:0]       alu_op2,
    input  logic [`PRN_WIDTH-1:0]  alu_dest_prn,
    input  logic [`ROBN_WIDTH-1:0] alu_robn,
    input  fu_pkg::opa_select_t    alu_opa_select,
    input  fu_pkg::opb_select_t    alu_opb_select,
    input  logic                   alu_cond_branch,
    input  logic                   alu_uncond_branch,
    // mult issue
    input  logic                   mult_valid,
    input  fu_pkg::inst_t          mult_inst,
    input  logic [`XLEN-1:0]       mult_pc,
    input  fu_pkg::mult_func_t     mult_func,
    input  logic [`XLEN-1:0]       mult_op1,
    input  logic [`XLEN-1:0]       mult_op2,
    input  logic [`PRN_WIDTH-1:0]  mult_dest_prn,
    input  logic [`ROBN_WIDTH-1:0] mult_robn,
    input  fu_pkg::opa_select_t    mult_opa_select,
    input  fu_pkg::opb_select_t    mult_opb_select,
    input  logic                   mult_avail,  // from completion select
    // alu completion
    output logic                   alu_prepared,
    output logic [`XLEN-1:0]       alu_result,
    output logic [`PRN_WIDTH-1:0]  alu_done_dest_prn,
    output logic [`ROBN_WIDTH-1:0] alu_done_robn,
    output logic                   alu_take_branch,
    // mult completion
    output logic                   mult_prepared,
    output logic [`XLEN-1:0]       mult_result,
    output logic [`PRN_WIDTH-1:0]  mult_done_dest_prn,
    output logic [`ROBN_WIDTH-1:0] mult_done_robn,
    // branch resolution to the rob
    output logic [`ROBN_WIDTH-1:0] rob_robn,
    output logic                   rob_executed,
    output logic                   rob_branch_taken,
    output logic [`XLEN-1:0]       rob_target_addr
);
    logic alu_cond_done;

    alu_unit i_alu_unit (
        .valid            (alu_valid),
        .inst             (alu_inst),
        .pc               (alu_pc),
        .func             (alu_func),
        .op1              (alu_op1),
        .op2              (alu_op2),
        .dest_prn         (alu_dest_prn),
        .robn             (alu_robn),
        .opa_select       (alu_opa_select),
        .opb_select       (alu_opb_select),
        .cond_branch      (alu_cond_branch),
        .uncond_branch    (alu_uncond_branch),
        .prepared         (alu_prepared),
        .result           (alu_result),
        .done_dest_prn    (alu_done_dest_prn),
        .done_robn        (alu_done_robn),
        .take_branch      (alu_take_branch),
        .cond_branch_done (alu_cond_done)
    );

    mult_unit i_mult_unit (
        .clock         (clock),
        .rst           (rst),
        .valid         (mult_valid),
        .inst          (mult_inst),
        .pc            (mult_pc),
        .func          (mult_func),
        .op1           (mult_op1),
        .op2           (mult_op2),
        .opa_select    (mult_opa_select),
        .opb_select    (mult_opb_select),
        .dest_prn      (mult_dest_prn),
        .robn          (mult_robn),
        .avail         (mult_avail),
        .prepared      (mult_prepared),
        .result        (mult_result),
        .done_dest_prn (mult_done_dest_prn),
        .done_robn     (mult_done_robn)
    );

    // rob record comes straight off the alu lane, same cycle
    assign rob_robn         = alu_done_robn;
    assign rob_executed     = alu_cond_done;   // only cond branches resolve here
    assign rob_branch_taken = alu_take_branch;
    assign rob_target_addr  = alu_result;      // pc + b_imm

endmodule

//--- fu_defs.svh
`ifndef FU_DEFS_SVH
`define FU_DEFS_SVH

// datapath widths
`define XLEN        32  // data and address width
`define PRN_WIDTH   6   // physical register tag, 64 regs
`define ROBN_WIDTH  5   // rob index, 32 entries

// multiplier pipeline depth, 2 or more
// stage one extends operands, last stage picks the word
`define MULT_STAGES 4

// results for an illegal select or function code
`define POISON_ALU  32'hfacebeec  // undefined alu func
`define POISON_OPA  32'hdeadface  // bad opa select
`define POISON_OPB  32'hfacefeed  // bad opb select

`endif

//--- fu_pkg.sv
package fu_pkg;

    // alu function codes, 6 of 16 unused
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_func_t;

    // RV32M multiply flavours
    typedef enum logic [1:0] {
        M_MUL    = 2'd0,  // low word
        M_MULH   = 2'd1,  // signed x signed, high word
        M_MULHSU = 2'd2,  // signed x unsigned, high word
        M_MULHU  = 2'd3   // unsigned x unsigned, high word
    } mult_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'd0,
        OPA_IS_PC   = 2'd1,
        OPA_IS_ZERO = 2'd2   // 3 is illegal
    } opa_select_t;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5  // 6, 7 illegal
    } opb_select_t;

    // one instruction word, six views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] off;   // imm[11:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] set;   // imm[4:0]
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       of;    // imm[12]
            logic [5:0] s;     // imm[10:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] et;    // imm[4:1]
            logic       f;     // imm[11]
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] up;   // imm[31:12]
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       of;    // imm[20]
            logic [9:0] et;    // imm[10:1]
            logic       s;     // imm[11]
            logic [7:0] f;     // imm[19:12]
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_t;

endpackage

//--- fu_properties.sv
`timescale 1ns/1ps
`include "fu_defs.svh"

// checks for fu, bound into every fu instance
module fu_properties (
    input logic                   clock, rst,
    input logic                   alu_valid, alu_cond_branch, alu_uncond_branch,
    input logic [`XLEN-1:0]       alu_inst, alu_pc, alu_op1, alu_op2,
    input logic [3:0]             alu_func,
    input logic [1:0]             alu_opa_select,
    input logic [2:0]             alu_opb_select,
    input logic [`PRN_WIDTH-1:0]  alu_dest_prn, alu_done_dest_prn,
    input logic [`ROBN_WIDTH-1:0] alu_robn, alu_done_robn, rob_robn,
    input logic                   mult_valid, mult_avail, mult_prepared,
    input logic [`XLEN-1:0]       mult_inst, mult_pc, mult_op1, mult_op2, mult_result,
    input logic [1:0]             mult_func, mult_opa_select,
    input logic [2:0]             mult_opb_select,
    input logic [`PRN_WIDTH-1:0]  mult_dest_prn, mult_done_dest_prn,
    input logic [`ROBN_WIDTH-1:0] mult_robn, mult_done_robn,
    input logic                   alu_prepared, alu_take_branch,
    input logic                   rob_executed, rob_branch_taken,
    input logic [`XLEN-1:0]       alu_result, rob_target_addr
);
    localparam int S  = `MULT_STAGES;
    localparam int EW = `XLEN + `PRN_WIDTH + `ROBN_WIDTH;  // result + tags

    int               fail_count = 0;  // assertion failures so far
    int               pending;         // products still owed by the pipe
    logic [EW-1:0]    exp_q[$];        // expected mult outputs, oldest first
    logic [EW-1:0]    head;
    logic             head_ok;
    logic [S-1:0]     acc_hist, av_hist;  // bit 0 is the last edge
    logic [`XLEN-1:0] alu_expect;
    logic             take_expect;

    function automatic logic [`XLEN-1:0] pick_opa(input logic [31:0] pc, op1,
                                                  input logic [1:0] sel);
        case (sel)
            2'd0:    return op1;
            2'd1:    return pc;
            2'd2:    return '0;
            default: return `POISON_OPA;
        endcase
    endfunction

    // immediates straight off the raw RISC-V bit positions
    function automatic logic [`XLEN-1:0] pick_opb(input logic [31:0] w, op2,
                                                  input logic [2:0] sel);
        case (sel)
            3'd0:    return op2;
            3'd1:    return {{21{w[31]}}, w[30:20]};
            3'd2:    return {{21{w[31]}}, w[30:25], w[11:7]};
            3'd3:    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            3'd4:    return {w[31:12], 12'b0};
            3'd5:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: return `POISON_OPB;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] alu_model(input logic [31:0] a, b,
                                                   input logic [3:0] f);
        case (f)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return {31'b0, $signed(a) < $signed(b)};
            4'd4:    return {31'b0, a < b};
            4'd5:    return a | b;
            4'd6:    return a ^ b;
            4'd7:    return a >> b[4:0];
            4'd8:    return a << b[4:0];
            4'd9:    return $signed(a) >>> b[4:0];
            default: return `POISON_ALU;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;  // reserved
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] product_word(input logic [31:0] a, b,
                                                      input logic [1:0] f);
        logic signed [32:0] ea, eb;
        logic signed [65:0] p;
        ea = {(f != 2'd3) & a[31], a};  // only mulhu has a unsigned
        eb = {~f[1] & b[31], b};        // mul, mulh have b signed
        p  = ea * eb;
        return (f == 2'd0) ? p[31:0] : p[63:32];
    endfunction

    assign alu_expect  = alu_model(pick_opa(alu_pc, alu_op1, alu_opa_select),
                                   pick_opb(alu_inst, alu_op2, alu_opb_select), alu_func);
    assign take_expect = alu_uncond_branch
                       | (alu_cond_branch & branch_model(alu_inst[14:12], alu_op1, alu_op2));

    // scoreboard, pop on a consumed output, push on an accepted op
    always @(posedge clock) begin
        if (rst) begin
            exp_q.delete();
            acc_hist <= '0;
            av_hist  <= '0;
        end else begin
            if (mult_prepared && mult_avail && exp_q.size() > 0)
                void'(exp_q.pop_front());
            if (mult_valid && mult_avail)
                exp_q.push_back({product_word(pick_opa(mult_pc, mult_op1, mult_opa_select),
                                              pick_opb(mult_inst, mult_op2, mult_opb_select),
                                              mult_func), mult_dest_prn, mult_robn});
            acc_hist <= {acc_hist[S-2:0], mult_valid && mult_avail};
            av_hist  <= {av_hist[S-2:0], mult_avail};
        end
        head_ok <= exp_q.size() > 0;
        head    <= (exp_q.size() > 0) ? exp_q[0] : '0;
        pending <= exp_q.size();
    end

    alu_prepared_chk: assert property (@(posedge clock) disable iff (rst)
        alu_prepared == alu_valid)
        else begin
            fail_count++;
            $error("[FAIL] %0t ns: alu_prepared %b, alu_valid %b", $time,
                   alu_prepared, alu_valid);
        end

    alu_result_chk: assert property (@(posedge clock) disable iff (rst)
        alu_prepared |-> alu_result == alu_expect && alu_done_dest_prn == alu_dest_prn
                         && alu_done_robn == alu_robn)
        else begin
            fail_count++;
            $error("[FAIL] %0t ns: alu_result %h, expected %h", $time, alu_result, alu_expect);
        end

    branch_chk: assert property (@(posedge clock) disable iff (rst)
        alu_prepared |-> alu_take_branch == take_expect)
        else begin
            fail_count++;
            $error("[FAIL] %0t ns: alu_take_branch %b, expected %b", $time,
                   alu_take_branch, take_expect);
        end

    // rob record follows the alu lane in the same cycle
    rob_chk: assert property (@(posedge clock) disable iff (rst)
        rob_executed == (alu_valid && alu_cond_branch) && rob_branch_taken == take_expect
        && rob_target_addr == alu_expect && rob_robn == alu_robn)
        else begin
            fail_count++;
            $error("[FAIL] %0t ns: rob executed %b taken %b target %h, expected %h", $time,
                   rob_executed, rob_branch_taken, rob_target_addr, alu_expect);
        end

    // accepted S edges ago with avail high since, so it is out now
    mult_latency_chk: assert property (@(posedge clock) disable iff (rst)
        acc_hist[S-1] && (&av_hist[S-2:0]) |-> mult_prepared)
        else begin
            fail_count++;
            $error("[FAIL] %0t ns: mult_prepared low %0d cycles after accept", $time, S - 1);
        end

    mult_order_chk: assert property (@(posedge clock) disable iff (rst)
        mult_prepared |-> head_ok
                          && {mult_result, mult_done_dest_prn, mult_done_robn} == head)
        else begin
            fail_count++;
            $error("[FAIL] %0t ns: mult output %h/%0d/%0d, expected %h (queued %b)", $time,
                   mult_result, mult_done_dest_prn, mult_done_robn, head, head_ok);
        end

    mult_reset_chk: assert property (@(posedge clock) $past(rst) |-> !mult_prepared)
        else begin
            fail_count++;
            $error("[FAIL] %0t ns: mult_prepared high right after reset", $time);
        end

endmodule

bind fu fu_properties i_fu_properties (.*);

//--- mult_unit.sv
`timescale 1ns/1ps
`include "fu_defs.svh"

// pipelined RV32M multiplier lane, whole pipe frozen while avail low
module mult_unit (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   valid,
    input  fu_pkg::inst_t          inst,
    input  logic [`XLEN-1:0]       pc,
    input  fu_pkg::mult_func_t     func,
    input  logic [`XLEN-1:0]       op1,
    input  logic [`XLEN-1:0]       op2,
    input  fu_pkg::opa_select_t    opa_select,
    input  fu_pkg::opb_select_t    opb_select,
    input  logic [`PRN_WIDTH-1:0]  dest_prn,
    input  logic [`ROBN_WIDTH-1:0] robn,
    input  logic                   avail,
    output logic                   prepared,
    output logic [`XLEN-1:0]       result,
    output logic [`PRN_WIDTH-1:0]  done_dest_prn,
    output logic [`ROBN_WIDTH-1:0] done_robn
);
    import fu_pkg::*;

    localparam int STAGES = `MULT_STAGES;
    localparam int OPW    = `XLEN + 1;              // extended operand
    localparam int PW     = 2 * `XLEN;              // product kept mod 2^64
    localparam int NCH    = STAGES - 1;             // one chunk of b per stage
    localparam int CW     = (OPW + NCH - 1) / NCH;  // chunk width
    localparam int BPW    = NCH * CW;               // b padded to whole chunks

    logic [`XLEN-1:0] opa, opb;
    logic             sa, sb;        // treat a / b as signed
    logic [OPW-1:0]   a_ext, b_ext;

    logic [STAGES-1:0]     vld;      // bit s is register s
    logic [`PRN_WIDTH-1:0]  prn_q  [STAGES];
    logic [`ROBN_WIDTH-1:0] robn_q [STAGES];
    logic [OPW-1:0]        a_q    [STAGES-1];
    logic [OPW-1:0]        b_q    [STAGES-1];
    mult_func_t            func_q [STAGES-1];
    logic [PW-1:0]         acc_q  [STAGES-1];
    logic [PW-1:0]         acc_nx [STAGES-1];
    logic [`XLEN-1:0]      res_q;

    // a times chunk k of b, shifted into place
    function automatic logic [PW-1:0] partial(input logic [OPW-1:0] a,
                                              input logic [OPW-1:0] b,
                                              input int k);
        logic [BPW-1:0] bp;
        logic [CW-1:0]  chunk;
        logic [PW-1:0]  aw, cw_ext;
        bp    = BPW'($signed(b));
        chunk = bp[k*CW +: CW];
        aw    = PW'($signed(a));
        if (k == NCH - 1)
            cw_ext = PW'($signed(chunk));  // top chunk carries the sign
        else
            cw_ext = PW'(chunk);
        return (aw * cw_ext) << (k * CW);
    endfunction

    operand_select i_operand_select (
        .inst       (inst),
        .pc         (pc),
        .op1        (op1),
        .op2        (op2),
        .opa_select (opa_select),
        .opb_select (opb_select),
        .opa        (opa),
        .opb        (opb)
    );

    always_comb begin
        case (func)
            M_MULHSU: {sa, sb} = 2'b10;
            M_MULHU:  {sa, sb} = 2'b00;
            default:  {sa, sb} = 2'b11;  // mul, mulh
        endcase
    end

    assign a_ext = {sa & opa[`XLEN-1], opa};
    assign b_ext = {sb & opb[`XLEN-1], opb};

    // accumulate one partial product per stage
    always_comb begin
        for (int s = 0; s < STAGES - 1; s++)
            acc_nx[s] = acc_q[s] + partial(a_q[s], b_q[s], s);
    end

    always_ff @(posedge clock) begin
        if (rst)
            vld <= '0;
        else if (avail)
            vld <= {vld[STAGES-2:0], valid};
    end

    always_ff @(posedge clock) begin
        if (avail) begin
            a_q[0]    <= a_ext;
            b_q[0]    <= b_ext;
            func_q[0] <= func;
            acc_q[0]  <= '0;
            prn_q[0]  <= dest_prn;
            robn_q[0] <= robn;
            for (int s = 1; s < STAGES; s++) begin
                prn_q[s]  <= prn_q[s-1];
                robn_q[s] <= robn_q[s-1];
            end
            for (int s = 1; s < STAGES - 1; s++) begin
                a_q[s]    <= a_q[s-1];
                b_q[s]    <= b_q[s-1];
                func_q[s] <= func_q[s-1];
                acc_q[s]  <= acc_nx[s-1];
            end
            // last stage keeps only the wanted word
            if (func_q[STAGES-2] == M_MUL)
                res_q <= acc_nx[STAGES-2][`XLEN-1:0];
            else
                res_q <= acc_nx[STAGES-2][PW-1:`XLEN];
        end
    end

    assign prepared      = vld[STAGES-1];
    assign result        = res_q;
    assign done_dest_prn = prn_q[STAGES-1];
    assign done_robn     = robn_q[STAGES-1];

endmodule

//--- operand_select.sv
`timescale 1ns/1ps
`include "fu_defs.svh"

// opA / opB muxes shared by both lanes
module operand_select (
    input  fu_pkg::inst_t       inst,
    input  logic [`XLEN-1:0]    pc,
    input  logic [`XLEN-1:0]    op1,
    input  logic [`XLEN-1:0]    op2,
    input  fu_pkg::opa_select_t opa_select,
    input  fu_pkg::opb_select_t opb_select,
    output logic [`XLEN-1:0]    opa,
    output logic [`XLEN-1:0]    opb
);
    import fu_pkg::*;

    logic [`XLEN-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;

    // immediates rebuilt from the format views, sign bit is inst[31] in all
    assign i_imm = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign s_imm = {{20{inst.s.off[6]}}, inst.s.off, inst.s.set};
    assign b_imm = {{19{inst.b.of}}, inst.b.of, inst.b.f, inst.b.s, inst.b.et, 1'b0};
    assign u_imm = {inst.u.up, 12'b0};  // low 12 zero
    assign j_imm = {{11{inst.j.of}}, inst.j.of, inst.j.f, inst.j.s, inst.j.et, 1'b0};

    always_comb begin
        case (opa_select)
            OPA_IS_RS1:  opa = op1;
            OPA_IS_PC:   opa = pc;   // auipc, jal, branch target
            OPA_IS_ZERO: opa = '0;   // lui
            default:     opa = `POISON_OPA;
        endcase
    end

    always_comb begin
        case (opb_select)
            OPB_IS_RS2:   opb = op2;
            OPB_IS_I_IMM: opb = i_imm;
            OPB_IS_S_IMM: opb = s_imm;
            OPB_IS_B_IMM: opb = b_imm;
            OPB_IS_U_IMM: opb = u_imm;
            OPB_IS_J_IMM: opb = j_imm;
            default:      opb = `POISON_OPB;
        endcase
    end

endmodule

//--- tb_fu.sv
`timescale 1ns/1ps
`include "fu_defs.svh"

module tb_fu;
    import fu_pkg::*;

    localparam int MAX_WAIT = 200;  // cycles per wait loop

    logic                   clock, rst;
    logic                   alu_valid, alu_cond_branch, alu_uncond_branch;
    inst_t                  alu_inst;
    logic [`XLEN-1:0]       alu_pc, alu_op1, alu_op2;
    alu_func_t              alu_func;
    logic [`PRN_WIDTH-1:0]  alu_dest_prn;
    logic [`ROBN_WIDTH-1:0] alu_robn;
    opa_select_t            alu_opa_select;
    opb_select_t            alu_opb_select;
    logic                   mult_valid, mult_avail;
    inst_t                  mult_inst;
    logic [`XLEN-1:0]       mult_pc, mult_op1, mult_op2;
    mult_func_t             mult_func;
    logic [`PRN_WIDTH-1:0]  mult_dest_prn;
    logic [`ROBN_WIDTH-1:0] mult_robn;
    opa_select_t            mult_opa_select;
    opb_select_t            mult_opb_select;
    logic                   alu_prepared, alu_take_branch, mult_prepared;
    logic [`XLEN-1:0]       alu_result, mult_result, rob_target_addr;
    logic [`PRN_WIDTH-1:0]  alu_done_dest_prn, mult_done_dest_prn;
    logic [`ROBN_WIDTH-1:0] alu_done_robn, mult_done_robn, rob_robn;
    logic                   rob_executed, rob_branch_taken;

    fu i_fu (.*);

    initial clock = 1'b0;
    always #10 clock = ~clock;  // 20 ns period

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clock);
        #1;
    endtask

    // corner values now and then
    function automatic logic [`XLEN-1:0] rand_word();
        case ($urandom_range(0, 5))
            0:       return 32'h8000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'(($urandom_range(0, 40)));
            default: return $urandom;
        endcase
    endfunction

    task automatic apply_reset();
        rst        = 1'b1;
        alu_valid  = 1'b0;
        mult_valid = 1'b0;
        repeat (2) step();
        rst = 1'b0;
    endtask

    // kind 0 plain op, 1 conditional branch, 2 jump
    task automatic issue_alu(input int kind);
        alu_valid         = ($urandom_range(0, 7) != 0);
        alu_inst          = $urandom;
        alu_pc            = $urandom;
        alu_op1           = rand_word();
        alu_op2           = ($urandom_range(0, 3) == 0) ? alu_op1 : rand_word();
        alu_dest_prn      = 6'($urandom);
        alu_robn          = 5'($urandom);
        alu_cond_branch   = (kind == 1);
        alu_uncond_branch = (kind == 2);
        alu_func          = alu_func_t'(4'($urandom_range(0, 11)));  // 10, 11 undefined
        alu_opa_select    = opa_select_t'(2'($urandom_range(0, 3)));
        alu_opb_select    = opb_select_t'(3'($urandom_range(0, 7)));
        if (kind == 1) begin  // target = pc + b_imm
            alu_func       = ALU_ADD;
            alu_opa_select = OPA_IS_PC;
            alu_opb_select = OPB_IS_B_IMM;
        end
        step();
    endtask

    // hold the op until an edge with avail high takes it
    task automatic issue_mult(input logic gaps);
        int  n;
        logic taken;
        n     = 0;
        taken = 1'b0;
        mult_valid      = 1'b1;
        mult_inst       = $urandom;
        mult_pc         = $urandom;
        mult_op1        = rand_word();
        mult_op2        = rand_word();
        mult_func       = mult_func_t'(2'($urandom));
        mult_dest_prn   = 6'($urandom);
        mult_robn       = 5'($urandom);
        mult_opa_select = opa_select_t'(2'($urandom_range(0, 3)));
        mult_opb_select = opb_select_t'(3'($urandom_range(0, 7)));
        while (!taken) begin
            if (n == MAX_WAIT) begin
                $display("multiplier never accepted an op, avail stayed low");
                $display("TESTBENCH FAILED");
                $fatal(1, "accept timeout");
            end
            mult_avail = gaps ? ($urandom_range(0, 3) != 0) : 1'b1;
            taken      = mult_avail;
            step();
            n++;
        end
        mult_valid = 1'b0;
        if (gaps && $urandom_range(0, 2) == 0) begin  // bubble
            mult_avail = ($urandom_range(0, 1) != 0);
            step();
        end
    endtask

    // avail high until every accepted product came back
    task automatic drain_mult();
        int n;
        n          = 0;
        mult_valid = 1'b0;
        mult_avail = 1'b1;
        while (i_fu.i_fu_properties.pending != 0) begin
            if (n == MAX_WAIT) begin
                $display("multiplier still owes results after the drain period");
                $display("TESTBENCH FAILED");
                $fatal(1, "drain timeout");
            end
            step();
            n++;
        end
        step();
    endtask

    // first assertion failure ends the run
    always @(negedge clock) begin
        if (i_fu.i_fu_properties.fail_count != 0) begin
            $display("[FAIL] %0t ns: fu assertion check failed", $time);
            $display("TESTBENCH FAILED");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        void'($urandom(78));
        rst = 1'b1;
        alu_valid = 1'b0;
        alu_inst = '0;
        alu_pc = '0;
        alu_func = ALU_ADD;
        alu_op1 = '0;
        alu_op2 = '0;
        alu_dest_prn = '0;
        alu_robn = '0;
        alu_opa_select = OPA_IS_RS1;
        alu_opb_select = OPB_IS_RS2;
        alu_cond_branch = 1'b0;
        alu_uncond_branch = 1'b0;
        mult_valid = 1'b0;
        mult_avail = 1'b1;
        mult_inst = '0;
        mult_pc = '0;
        mult_func = M_MUL;
        mult_op1 = '0;
        mult_op2 = '0;
        mult_dest_prn = '0;
        mult_robn = '0;
        mult_opa_select = OPA_IS_RS1;
        mult_opb_select = OPB_IS_RS2;
        apply_reset();

        repeat (400) issue_alu($urandom_range(0, 2));
        alu_valid = 1'b0;

        repeat (40) issue_mult(1'b0);  // back to back, fixed latency
        drain_mult();
        repeat (80) issue_mult(1'b1);  // random back-pressure
        drain_mult();

        repeat (3) issue_mult(1'b0);  // reset with ops in flight
        apply_reset();
        repeat (30) issue_mult(1'b1);
        drain_mult();

        step();
        if (i_fu.i_fu_properties.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("[FAIL] %0t ns: fu assertion check failed", $time);
            $display("TESTBENCH FAILED");
            $fatal(1, "assertion failure");
        end
    end

endmodule
